/* verilog.f */
src/noc_flit_pkg.sv
src/noc_cfg_pkg.sv
src/noc_link_if.sv
src/noc_buffer.sv
src/noc_packet_arbiter.sv
src/noc_merge_top.sv
bench/noc_merge_tb.sv

/* bench/noc_merge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Random traffic through the two-input packet merge, checked per source
module noc_merge_tb
   import noc_flit_pkg::*;
   import noc_cfg_pkg::*;
();

   logic      clk;
   logic      rst;
   flit_t     in0_flit;
   logic      in0_last;
   logic      in0_valid;
   logic      in0_ready;
   flit_t     in1_flit;
   logic      in1_last;
   logic      in1_valid;
   logic      in1_ready;
   flit_t     out_flit;
   logic      out_last;
   logic      out_valid;
   logic      out_ready;
   pkt_size_t out_size;
   port_idx_t out_src;

   logic [31:0] lfsr;                 // Stimulus generator state
   logic        rdy_random;           // out_ready toggled randomly when set
   int          timeout_cycles;

   // Expected traffic per source
   flit_t       q0_flit [$];
   logic        q0_last [$];
   pkt_size_t   q0_len  [$];
   flit_t       q1_flit [$];
   logic        q1_last [$];
   pkt_size_t   q1_len  [$];

   logic        in_pkt;               // Output is mid-packet
   port_idx_t   cur_src;
   pkt_size_t   cur_size;
   port_idx_t   src_log [$];          // Source of each finished packet

   noc_merge_top UUT (
      .clk       (clk),
      .rst       (rst),
      .in0_flit  (in0_flit),
      .in0_last  (in0_last),
      .in0_valid (in0_valid),
      .in0_ready (in0_ready),
      .in1_flit  (in1_flit),
      .in1_last  (in1_last),
      .in1_valid (in1_valid),
      .in1_ready (in1_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_size  (out_size),
      .out_src   (out_src)
   );

   always #4 clk = ~clk;  // 8 ns period

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic fail_plain(input string msg);
      $display("Error at %0t: %s", $time, msg);
      stop_run();
   endtask

   task automatic check_flit(input string name, input flit_t exp, input flit_t act);
      if (act !== exp) begin
         $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_size(input string name, input pkt_size_t exp, input pkt_size_t act);
      if (act !== exp) begin
         $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_port(input string name, input port_idx_t exp, input port_idx_t act);
      if (act !== exp) begin
         $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic drive_in(input port_idx_t port, input flit_t f, input logic l, input logic v);
      if (port == 0) begin
         in0_flit  = f;
         in0_last  = l;
         in0_valid = v;
      end else begin
         in1_flit  = f;
         in1_last  = l;
         in1_valid = v;
      end
   endtask

   task automatic model_push(input port_idx_t port, input flit_t f, input logic l);
      if (port == 0) begin
         q0_flit.push_back(f);
         q0_last.push_back(l);
      end else begin
         q1_flit.push_back(f);
         q1_last.push_back(l);
      end
   endtask

   task automatic model_len(input port_idx_t port, input pkt_size_t len);
      if (port == 0)
         q0_len.push_back(len);
      else
         q1_len.push_back(len);
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
   endtask

   // Called at 1 ns past an edge, returns at the same phase
   task automatic send_flit(input port_idx_t port, input flit_t f, input logic l);
      int   waited;
      logic rdy;
      waited = 0;
      rdy    = 1'b0;
      drive_in(port, f, l, 1'b1);
      while (!rdy) begin
         @(negedge clk);
         rdy = (port == 0) ? in0_ready : in1_ready;  // Stable until next edge
         if (!rdy) begin
            waited++;
            if (waited > timeout_cycles)
               fail_plain("input never became ready for a flit");
         end
      end
      model_push(port, f, l);  // Transfers on the coming edge
      idle_cycle();
      drive_in(port, '0, 1'b0, 1'b0);
   endtask

   task automatic send_packet(input port_idx_t port, input pkt_size_t len, input logic gaps);
      model_len(port, len);
      for (int i = 0; i < len; i++) begin
         if (gaps && rand_bits(2) == 0)
            idle_cycle();              // Random valid gap
         send_flit(port, flit_t'(rand_bits(32)), i == len - 1);
      end
   endtask

   // Until every sent flit has come out
   task automatic wait_drain();
      int waited;
      waited = 0;
      while (q0_flit.size() != 0 || q1_flit.size() != 0 || in_pkt) begin
         @(posedge clk);
         waited++;
         if (waited > timeout_cycles)
            fail_plain("output did not drain all sent packets");
      end
      #1;
   endtask

   // One output transfer against the model of its source
   task automatic check_output();
      flit_t     exp_flit;
      logic      exp_last;
      pkt_size_t exp_len;
      if (out_src == 0) begin
         if (q0_flit.size() == 0)
            fail_plain("output flit from port 0 that was never sent");
         exp_flit = q0_flit.pop_front();
         exp_last = q0_last.pop_front();
      end else begin
         if (q1_flit.size() == 0)
            fail_plain("output flit from port 1 that was never sent");
         exp_flit = q1_flit.pop_front();
         exp_last = q1_last.pop_front();
      end
      if (!in_pkt) begin
         exp_len = (out_src == 0) ? q0_len.pop_front() : q1_len.pop_front();
         check_size("out_size", exp_len, out_size);
         cur_src  = out_src;
         cur_size = out_size;
         in_pkt   = 1'b1;
      end else begin
         check_port("out_src", cur_src, out_src);     // No interleaving
         check_size("out_size", cur_size, out_size);
      end
      check_flit("out_flit", exp_flit, out_flit);
      check_flag("out_last", exp_last, out_last);
      if (out_last) begin
         in_pkt = 1'b0;
         src_log.push_back(out_src);
      end
   endtask

   // Output sampled mid-cycle, transfer happens on next rising edge
   always @(negedge clk) begin
      if (!rst && out_valid && out_ready)
         check_output();
   end

   always @(posedge clk) begin
      #1;
      if (rdy_random)
         out_ready = (rand_bits(2) != 0);  // Ready 3 of 4 cycles
   end

   initial begin
      pkt_size_t len;
      clk = 1'b0;
      rst = 1'b1;
      drive_in(0, '0, 1'b0, 1'b0);
      drive_in(1, '0, 1'b0, 1'b0);
      out_ready      = 1'b0;
      rdy_random     = 1'b0;
      lfsr           = 32'h53b3;
      timeout_cycles = 2000;
      in_pkt         = 1'b0;
      cur_src        = '0;
      cur_size       = '0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      // Idle state after reset
      @(negedge clk);
      check_flag("out_valid", 1'b0, out_valid);
      check_flag("in0_ready", 1'b1, in0_ready);
      check_flag("in1_ready", 1'b1, in1_ready);
      idle_cycle();

      // Round robin with two packets preloaded per port.
      // First packets finish on the same edge so the reset priority picks
      len = pkt_size_t'(rand_bits(2) + 1);
      fork
         send_packet(0, len, 1'b0);
         send_packet(1, len, 1'b0);
      join
      send_packet(0, pkt_size_t'(rand_bits(2) + 1), 1'b0);
      send_packet(1, pkt_size_t'(rand_bits(2) + 1), 1'b0);
      out_ready = 1'b1;
      wait_drain();
      if (src_log.size() != 4)
         fail_plain("round robin phase did not output four packets");
      for (int i = 0; i < 4; i++)
         check_port("out_src", port_idx_t'(i % 2), src_log[i]);

      // Full buffer with output stalled
      out_ready = 1'b0;
      model_len(0, pkt_size_t'(IN_DEPTH + 1));
      for (int i = 0; i <= IN_DEPTH; i++) begin
         check_flag("in0_ready", 1'b1, in0_ready);
         send_flit(0, flit_t'(rand_bits(32)), i == IN_DEPTH);
      end
      check_flag("in0_ready", 1'b0, in0_ready);   // Exactly IN_DEPTH+1 stored
      repeat (4) begin
         idle_cycle();
         check_flag("in0_ready", 1'b0, in0_ready);
      end
      out_ready = 1'b1;
      wait_drain();

      // Last flit withheld, nothing may leave
      len = pkt_size_t'(rand_bits(3) % 7 + 2);
      model_len(1, len);
      for (int i = 0; i < len - 1; i++)
         send_flit(1, flit_t'(rand_bits(32)), 1'b0);
      repeat (20) begin
         @(negedge clk);
         check_flag("out_valid", 1'b0, out_valid);
      end
      idle_cycle();
      send_flit(1, flit_t'(rand_bits(32)), 1'b1);
      wait_drain();

      // Random traffic on both ports, random back-pressure
      rdy_random = 1'b1;
      fork
         for (int i = 0; i < 40; i++)
            send_packet(0, pkt_size_t'(rand_bits(3) + 1), 1'b1);
         for (int i = 0; i < 40; i++)
            send_packet(1, pkt_size_t'(rand_bits(3) + 1), 1'b1);
      join
      wait_drain();
      rdy_random = 1'b0;

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

/* src/noc_merge_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Two-input packet merge
// Each input is buffered until whole packets are stored, then the
// arbiter forwards complete packets one at a time to the single output.
module noc_merge_top
   import noc_flit_pkg::*;
   import noc_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      rst,

   // Input port 0
   input  flit_t     in0_flit,
   input  logic      in0_last,
   input  logic      in0_valid,
   output logic      in0_ready,

   // Input port 1
   input  flit_t     in1_flit,
   input  logic      in1_last,
   input  logic      in1_valid,
   output logic      in1_ready,

   // Merged output
   output flit_t     out_flit,
   output logic      out_last,
   output logic      out_valid,
   input  logic      out_ready,
   output pkt_size_t out_size,
   output port_idx_t out_src
);

   pkt_size_t head_size0;
   pkt_size_t head_size1;

   noc_link_if in0_link ();    // Port 0 into buffer
   noc_link_if in1_link ();    // Port 1 into buffer
   noc_link_if buf0_link ();   // Buffer 0 into arbiter
   noc_link_if buf1_link ();   // Buffer 1 into arbiter

   // Top ports onto the input links
   assign in0_link.flit  = in0_flit;
   assign in0_link.last  = in0_last;
   assign in0_link.valid = in0_valid;
   assign in0_ready      = in0_link.ready;

   assign in1_link.flit  = in1_flit;
   assign in1_link.last  = in1_last;
   assign in1_link.valid = in1_valid;
   assign in1_ready      = in1_link.ready;

   noc_buffer #(
      .DEPTH     (IN_DEPTH)
   ) u_buf0 (
      .clk       (clk),
      .rst       (rst),
      .in_link   (in0_link),
      .out_link  (buf0_link),
      .head_size (head_size0)
   );

   noc_buffer #(
      .DEPTH     (IN_DEPTH)
   ) u_buf1 (
      .clk       (clk),
      .rst       (rst),
      .in_link   (in1_link),
      .out_link  (buf1_link),
      .head_size (head_size1)
   );

   // Whole-packet round robin onto the output
   noc_packet_arbiter u_arb (
      .clk       (clk),
      .rst       (rst),
      .in_link0  (buf0_link),
      .in_link1  (buf1_link),
      .size0     (head_size0),
      .size1     (head_size1),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_size  (out_size),
      .out_src   (out_src)
   );

endmodule

`default_nettype wire

/* src/noc_packet_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// Round-robin packet arbiter
// Grants one buffer holding a complete packet and streams that packet
// to the output without interleaving. One idle cycle per packet for
// the arbitration itself.
module noc_packet_arbiter
   import noc_flit_pkg::*;
   import noc_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   noc_link_if.rx    in_link0,
   noc_link_if.rx    in_link1,
   input  pkt_size_t size0,      // Head packet size of buffer 0
   input  pkt_size_t size1,      // Head packet size of buffer 1
   output flit_t     out_flit,
   output logic      out_last,
   output logic      out_valid,
   input  logic      out_ready,
   output pkt_size_t out_size,   // Total size of packet in flight
   output port_idx_t out_src     // Source port of packet in flight
);

   arb_state_e state;
   port_idx_t  prio;             // Port looked at first
   port_idx_t  pick;             // Winner this cycle
   port_idx_t  src;              // Latched grant
   pkt_size_t  size;             // Latched packet size
   logic [NUM_IN-1:0] valid_vec;
   pkt_size_t  size_vec [NUM_IN];
   logic       any_valid;
   logic       sel1;
   logic       fwd;
   logic       done;

   assign valid_vec   = {in_link1.valid, in_link0.valid};
   assign size_vec[0] = size0;
   assign size_vec[1] = size1;
   assign any_valid   = |valid_vec;

   // Favoured port wins if it has a packet, else the other one
   assign pick = valid_vec[prio] ? prio : ~prio;

   assign fwd  = (state == ARB_FWD);
   assign sel1 = (src == port_idx_t'(1));

   // Output mux follows the latched grant
   always_comb begin
      if (sel1) begin
         out_flit  = in_link1.flit;
         out_last  = in_link1.last;
         out_valid = fwd & in_link1.valid;
      end else begin
         out_flit  = in_link0.flit;
         out_last  = in_link0.last;
         out_valid = fwd & in_link0.valid;
      end
   end

   // Ready only to the granted buffer
   assign in_link0.ready = fwd & ~sel1 & out_ready;
   assign in_link1.ready = fwd & sel1 & out_ready;

   assign done = out_valid & out_ready & out_last;  // Packet tail leaves

   // FSM and round-robin pointer
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ARB_IDLE;
         prio  <= '0;              // Port 0 first after reset
      end else begin
         case (state)
            ARB_IDLE: begin
               if (any_valid)
                  state <= ARB_FWD;
            end
            ARB_FWD: begin
               if (done) begin
                  state <= ARB_IDLE;
                  prio  <= ~src;   // Other port goes next
               end
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   // Grant capture, held for the whole packet
   always_ff @(posedge clk) begin
      if (state == ARB_IDLE && any_valid) begin
         src  <= pick;
         size <= size_vec[pick];
      end
   end

   assign out_src  = src;
   assign out_size = size;

endmodule

`default_nettype wire

/* src/noc_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// Full-packet flit FIFO
// LUT-RAM storage plus one output register, so real capacity is DEPTH+1.
// A flit written into an empty (or emptying) FIFO bypasses the RAM and
// lands in the output register directly, giving one cycle minimum latency.
// Output is only offered once a complete packet sits in the buffer.
module noc_buffer
   import noc_flit_pkg::*;
   import noc_cfg_pkg::*;
#(
   parameter int DEPTH = IN_DEPTH  // Must be a power of two
)(
   input  logic      clk,
   input  logic      rst,
   noc_link_if.rx    in_link,
   noc_link_if.tx    out_link,
   output pkt_size_t head_size     // Flits left in head packet, 0 if none complete
);

   localparam int AW = $clog2(DEPTH);  // RAM index width

   // Elaboration-time parameter check
   if ((1 << AW) != DEPTH) begin : g_depth_chk
      $fatal(1, "noc_buffer: DEPTH must be a power of two");
   end

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;          // Flits stored, RAM plus output register
   logic          fifo_wr;
   logic          fifo_rd;
   logic          ram_wr;
   logic          ram_rd;
   logic          bypass;

   logic [FLIT_W:0] ram [DEPTH];  // {last, flit}

   logic [DEPTH:0] last_buf;      // Last flags, newest at bit 0
   logic [DEPTH:0] last_shift;    // Oldest stored flag moved to top bit
   logic [AW:0]    head_pos;      // Top-most set bit of last_shift
   logic [AW:0]    size_cnt;

   assign in_link.ready = (count != (AW+1)'(DEPTH + 1));  // Full at DEPTH+1
   assign fifo_wr = in_link.valid & in_link.ready;
   assign fifo_rd = out_link.valid & out_link.ready;

   // Write goes straight to the output register when it would be next out
   assign bypass = (count == '0) | ((count == (AW+1)'(1)) & fifo_rd);
   assign ram_wr = fifo_wr & ~bypass;
   assign ram_rd = fifo_rd & (count > (AW+1)'(1));  // Refill output reg from RAM

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (fifo_wr & ~fifo_rd)
            count <= count + 1'b1;
         else if (fifo_rd & ~fifo_wr)
            count <= count - 1'b1;
         if (ram_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (ram_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Dual-port RAM, single clock
   always_ff @(posedge clk) begin
      if (ram_wr)
         ram[wr_ptr] <= {in_link.last, in_link.flit};
   end

   // Output register
   always_ff @(posedge clk) begin
      if (ram_rd) begin
         out_link.flit <= ram[rd_ptr][FLIT_W-1:0];
         out_link.last <= ram[rd_ptr][FLIT_W];
      end else if (fifo_wr & bypass) begin
         out_link.flit <= in_link.flit;  // Write-through
         out_link.last <= in_link.last;
      end
   end

   // Flag history shifts on every write. Bits above count are stale
   // and drop off the top in last_shift
   always_ff @(posedge clk) begin
      if (fifo_wr)
         last_buf <= {last_buf[DEPTH-1:0], in_link.last};
   end

   // Align oldest stored flit to bit DEPTH
   assign last_shift = last_buf << ((AW+1)'(DEPTH + 1) - count);

   // Highest set bit is the first stored last flag
   always_comb begin
      head_pos = (AW+1)'(DEPTH + 1);  // No last stored
      for (int i = 0; i <= DEPTH; i++) begin
         if (last_shift[i])
            head_pos = (AW+1)'(i);    // Later hits are older flits
      end
   end

   // Distance from head flit to that last flag, inclusive
   assign size_cnt  = (AW+1)'(DEPTH + 1) - head_pos;
   assign head_size = pkt_size_t'(size_cnt);

   // Offer only a complete packet
   assign out_link.valid = |last_shift;

endmodule

`default_nettype wire

/* src/noc_link_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One flit link with valid/ready handshake and packet end marker
interface noc_link_if
   import noc_flit_pkg::*;
();

   flit_t flit;   // Payload
   logic  last;   // Final flit of packet
   logic  valid;  // Sender holds flit, last, valid until accepted
   logic  ready;  // Receiver can take a flit this cycle

   // Sending side
   modport tx (
      output flit,
      output last,
      output valid,
      input  ready
   );

   // Receiving side
   modport rx (
      input  flit,
      input  last,
      input  valid,
      output ready
   );

endinterface

`default_nettype wire

/* src/noc_cfg_pkg.sv */
`default_nettype none

// Merge stage configuration, shared by RTL and bench
package noc_cfg_pkg;

   localparam int NUM_IN   = 2;  // Input ports into the merge
   localparam int IN_DEPTH = 8;  // RAM depth per buffer, power of two

   // Largest packet is IN_DEPTH+1 flits because of the output register,
   // so the size needs one bit above the RAM index
   localparam int SIZE_W = $clog2(IN_DEPTH) + 1;

   typedef logic [SIZE_W-1:0] pkt_size_t;          // Packet length in flits
   typedef logic [$clog2(NUM_IN)-1:0] port_idx_t;  // Input port number

endpackage

`default_nettype wire

/* src/noc_flit_pkg.sv */
`default_nettype none

// Flit format and arbiter states
package noc_flit_pkg;

   localparam int FLIT_W = 32;  // One flit is one word

   typedef logic [FLIT_W-1:0] flit_t;

   // Packet arbiter FSM
   typedef enum logic {
      ARB_IDLE = 1'b0,  // Choosing next packet
      ARB_FWD  = 1'b1   // Forwarding granted packet
   } arb_state_e;

endpackage

`default_nettype wire
